//--- cia_timer_top.f
source/cia_timer_pkg.sv
source/cia_timer.sv
source/cia_irq_ctrl.sv
source/cia_axil_regs.sv
source/cia_timer_top.sv
verif/cia_timer_properties.sv
verif/cia_timer_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module cia_timer_tb \
  -f cia_timer_top.f -o sim_cia_timer || exit 1
./obj_dir/sim_cia_timer > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1 || grep -q "all tests passed" sim.log

//--- source/cia_axil_regs.sv
/* AXI4-Lite slave with separate write and read channel FSMs,
   register select strobes and the read data mux */
`timescale 1ns/1ps

module cia_axil_regs #(
  parameter int AXIL_ADDR_WIDTH = cia_timer_pkg::AXIL_ADDR_WIDTH_DEFAULT
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [AXIL_ADDR_WIDTH-1:0]  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  cia_timer_pkg::axil_data_t   wdata,
  input  logic [3:0]                  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output cia_timer_pkg::axil_resp_t   bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [AXIL_ADDR_WIDTH-1:0]  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output cia_timer_pkg::axil_data_t   rdata,
  output cia_timer_pkg::axil_resp_t   rresp,
  output logic                        rvalid,
  input  logic                        rready,
  input  cia_timer_pkg::reg_byte_t    ta_data,
  input  cia_timer_pkg::reg_byte_t    tb_data,
  input  cia_timer_pkg::reg_byte_t    icr_data,
  output logic                        wr,
  output logic                        rd,
  output cia_timer_pkg::reg_byte_t    data_in,
  output logic                        ta_lo,
  output logic                        ta_hi,
  output logic                        ta_cr,
  output logic                        tb_lo,
  output logic                        tb_hi,
  output logic                        tb_cr,
  output logic                        icr_sel
);
  import cia_timer_pkg::*;

  typedef logic [AXIL_ADDR_WIDTH-1:0] addr_t;

  axil_state_t wstate;
  axil_state_t rstate;
  addr_t       waddr;
  addr_t       raddr;
  logic        wstrb_lo;
  logic        aw_hs;
  logic        ar_hs;
  logic [6:0]  sel;

  // One-hot hit vector in order TA_LO, TA_HI, TB_LO, TB_HI, ICR, CRA, CRB
  function automatic logic [6:0] decode(input addr_t addr);
    logic [6:0] hit;
    hit[0] = (addr == addr_t'(ADDR_TA_LO));
    hit[1] = (addr == addr_t'(ADDR_TA_HI));
    hit[2] = (addr == addr_t'(ADDR_TB_LO));
    hit[3] = (addr == addr_t'(ADDR_TB_HI));
    hit[4] = (addr == addr_t'(ADDR_ICR));
    hit[5] = (addr == addr_t'(ADDR_CRA));
    hit[6] = (addr == addr_t'(ADDR_CRB));
    return hit;
  endfunction

  assign aw_hs   = (wstate == IDLE) && awvalid && wvalid;
  assign awready = aw_hs;
  assign wready  = aw_hs;
  // A read waits when a write is accepted on the same edge, so strobes never overlap
  assign ar_hs   = (rstate == IDLE) && arvalid && !aw_hs;
  assign arready = ar_hs;

  assign bvalid = (wstate != IDLE);
  assign rvalid = (rstate == RESP);
  assign wr     = (wstate == ACCESS) && wstrb_lo;
  assign rd     = (rstate == ACCESS);

  always_ff @(posedge clk) begin
    if (rst) begin
      wstate <= IDLE;
    end else begin
      case (wstate)
        IDLE:    if (aw_hs) wstate <= ACCESS;
        ACCESS:  wstate <= bready ? IDLE : RESP;
        RESP:    if (bready) wstate <= IDLE;
        default: wstate <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rstate <= IDLE;
    end else begin
      case (rstate)
        IDLE:    if (ar_hs) rstate <= ACCESS;
        ACCESS:  rstate <= RESP;
        RESP:    if (rready) rstate <= IDLE;
        default: rstate <= IDLE;
      endcase
    end
  end

  // Accepted address, data and write response
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      waddr    <= awaddr;
      data_in  <= wdata[7:0];
      wstrb_lo <= wstrb[0];
      bresp    <= (|decode(awaddr)) ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_hs) begin
      raddr <= araddr;
    end
  end

  // Unselected sources drive zero, so the OR is the mux
  always_ff @(posedge clk) begin
    if (rstate == ACCESS) begin
      rdata <= axil_data_t'(ta_data | tb_data | icr_data);
      rresp <= (|decode(raddr)) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign sel = (wr ? decode(waddr) : 7'd0) | (rd ? decode(raddr) : 7'd0);

  assign ta_lo   = sel[0];
  assign ta_hi   = sel[1];
  assign tb_lo   = sel[2];
  assign tb_hi   = sel[3];
  assign icr_sel = sel[4];
  assign ta_cr   = sel[5];
  assign tb_cr   = sel[6];

endmodule

//--- source/cia_irq_ctrl.sv
/* Interrupt flags and mask for both timers, read-to-clear */
`timescale 1ns/1ps

module cia_irq_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr,
  input  logic                     rd,
  input  logic                     icr_sel,
  input  cia_timer_pkg::reg_byte_t data_in,
  input  logic                     ta_ovf,
  input  logic                     tb_ovf,
  output cia_timer_pkg::reg_byte_t icr_data,
  output logic                     irq
);
  import cia_timer_pkg::*;

  logic [1:0] flags;
  logic [1:0] mask;
  logic [1:0] flag_set;
  logic [1:0] wr_bits;
  logic       flag_clr;

  always_comb begin
    flag_set         = '0;
    flag_set[ICR_TA] = ta_ovf;
    flag_set[ICR_TB] = tb_ovf;
    wr_bits          = '0;
    wr_bits[ICR_TA]  = data_in[ICR_TA];
    wr_bits[ICR_TB]  = data_in[ICR_TB];
  end

  assign flag_clr = rd && icr_sel;

  // A new underflow wins over a clearing read on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flag_clr) begin
      flags <= flag_set;
    end else begin
      flags <= flags | flag_set;
    end
  end

  // Set-or-clear write of the mask bits
  always_ff @(posedge clk) begin
    if (rst) begin
      mask <= '0;
    end else if (wr && icr_sel) begin
      if (data_in[ICR_SET]) begin
        mask <= mask | wr_bits;
      end else begin
        mask <= mask & ~wr_bits;
      end
    end
  end

  assign irq = |(flags & mask);

  always_comb begin
    icr_data = '0;
    if (rd && icr_sel) begin
      icr_data[ICR_SET] = irq;
      icr_data[ICR_TA]  = flags[ICR_TA];
      icr_data[ICR_TB]  = flags[ICR_TB];
    end
  end

endmodule

//--- source/cia_timer.sv
/* 16-bit interval timer with latches, control register,
   automatic reload and a registered underflow pulse */
`timescale 1ns/1ps

module cia_timer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr,
  input  logic                     rd,
  input  logic                     tlo,
  input  logic                     thi,
  input  logic                     tcr,
  input  cia_timer_pkg::reg_byte_t data_in,
  input  logic                     tick,
  input  logic                     cascade,
  output cia_timer_pkg::reg_byte_t data_out,
  output logic                     ovf
);
  import cia_timer_pkg::*;

  timer_cnt_t cnt;
  timer_cnt_t load_val;
  reg_byte_t  latch_lo;
  reg_byte_t  latch_hi;
  reg_byte_t  cr_byte;
  logic       start;
  logic       oneshot;
  logic       inmode;
  logic       forceload;
  logic       thi_load;
  logic       count;
  logic       zero;
  logic       underflow;
  logic       reload;

  assign load_val  = {latch_hi, latch_lo};
  // Count source is the top-level tick or the other timer's underflow
  assign count     = inmode ? cascade : tick;
  assign zero      = (cnt == '0);
  assign underflow = start && count && zero;
  assign reload    = thi_load || forceload || underflow;

  always_ff @(posedge clk) begin
    if (rst) begin
      latch_lo <= 8'hFF;
      latch_hi <= 8'hFF;
    end else begin
      if (wr && tlo) begin
        latch_lo <= data_in;
      end
      if (wr && thi) begin
        latch_hi <= data_in;
      end
    end
  end

  // Load requests act one cycle after the write, once the latch holds the byte
  always_ff @(posedge clk) begin
    if (rst) begin
      forceload <= 1'b0;
      thi_load  <= 1'b0;
    end else begin
      forceload <= wr && tcr && data_in[CR_FORCELOAD];
      thi_load  <= wr && thi && (!start || oneshot);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start   <= 1'b0;
      oneshot <= 1'b0;
      inmode  <= 1'b0;
    end else if (wr && tcr) begin
      start   <= data_in[CR_START];
      oneshot <= data_in[CR_ONESHOT];
      inmode  <= data_in[CR_INMODE];
    end else if (thi_load && oneshot) begin
      // One-shot timer restarts on a high-byte load
      start <= 1'b1;
    end else if (underflow && oneshot) begin
      start <= 1'b0;
    end
  end

  // All reload sources take the same latch value
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= 16'hFFFF;
    end else if (reload) begin
      cnt <= load_val;
    end else if (start && count) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Registered so that two timers cascaded on each other form no loop
  always_ff @(posedge clk) begin
    if (rst) begin
      ovf <= 1'b0;
    end else begin
      ovf <= underflow;
    end
  end

  // Force-load is a strobe and never reads back
  always_comb begin
    cr_byte            = '0;
    cr_byte[CR_START]   = start;
    cr_byte[CR_ONESHOT] = oneshot;
    cr_byte[CR_INMODE]  = inmode;
  end

  always_comb begin
    data_out = '0;
    if (rd) begin
      if (tlo) begin
        data_out = cnt[7:0];
      end else if (thi) begin
        data_out = cnt[15:8];
      end else if (tcr) begin
        data_out = cr_byte;
      end
    end
  end

endmodule

//--- source/cia_timer_pkg.sv
/* Shared widths, register map, control and interrupt bit positions,
   AXI response codes and the bus channel state type */
package cia_timer_pkg;

  // Smallest bus address width that reaches every register
  localparam int AXIL_ADDR_WIDTH_DEFAULT = 5;

  typedef logic [15:0] timer_cnt_t;
  typedef logic [7:0]  reg_byte_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Byte addresses on the bus
  localparam int unsigned ADDR_TA_LO = 'h00;
  localparam int unsigned ADDR_TA_HI = 'h04;
  localparam int unsigned ADDR_TB_LO = 'h08;
  localparam int unsigned ADDR_TB_HI = 'h0C;
  localparam int unsigned ADDR_ICR   = 'h10;
  localparam int unsigned ADDR_CRA   = 'h14;
  localparam int unsigned ADDR_CRB   = 'h18;

  // Control register bits
  localparam int CR_START     = 0;
  localparam int CR_ONESHOT   = 3;
  localparam int CR_FORCELOAD = 4;
  localparam int CR_INMODE    = 5;

  // Interrupt control bits
  localparam int ICR_TA  = 0;
  localparam int ICR_TB  = 1;
  localparam int ICR_SET = 7;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } axil_state_t;

endpackage

//--- source/cia_timer_top.sv
/* Dual interval timer top level with AXI4-Lite slave,
   timers A and B and the interrupt controller */
`timescale 1ns/1ps

module cia_timer_top #(
  parameter int AXIL_ADDR_WIDTH = cia_timer_pkg::AXIL_ADDR_WIDTH_DEFAULT
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       tick,
  input  logic [AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  cia_timer_pkg::axil_data_t  wdata,
  input  logic [3:0]                 wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output cia_timer_pkg::axil_resp_t  bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output cia_timer_pkg::axil_data_t  rdata,
  output cia_timer_pkg::axil_resp_t  rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       irq
);
  import cia_timer_pkg::*;

  logic      wr;
  logic      rd;
  reg_byte_t data_in;
  logic      ta_lo;
  logic      ta_hi;
  logic      ta_cr;
  logic      tb_lo;
  logic      tb_hi;
  logic      tb_cr;
  logic      icr_sel;
  reg_byte_t ta_data;
  reg_byte_t tb_data;
  reg_byte_t icr_data;
  logic      ta_ovf;
  logic      tb_ovf;

  cia_axil_regs #(
    .AXIL_ADDR_WIDTH(AXIL_ADDR_WIDTH)
  ) axil_regs (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .ta_data(ta_data), .tb_data(tb_data), .icr_data(icr_data),
    .wr(wr), .rd(rd), .data_in(data_in),
    .ta_lo(ta_lo), .ta_hi(ta_hi), .ta_cr(ta_cr),
    .tb_lo(tb_lo), .tb_hi(tb_hi), .tb_cr(tb_cr),
    .icr_sel(icr_sel)
  );

  // Each timer can count the other's underflow
  cia_timer timer_a (
    .clk(clk), .rst(rst), .wr(wr), .rd(rd),
    .tlo(ta_lo), .thi(ta_hi), .tcr(ta_cr), .data_in(data_in),
    .tick(tick), .cascade(tb_ovf),
    .data_out(ta_data), .ovf(ta_ovf)
  );

  cia_timer timer_b (
    .clk(clk), .rst(rst), .wr(wr), .rd(rd),
    .tlo(tb_lo), .thi(tb_hi), .tcr(tb_cr), .data_in(data_in),
    .tick(tick), .cascade(ta_ovf),
    .data_out(tb_data), .ovf(tb_ovf)
  );

  cia_irq_ctrl irq_ctrl (
    .clk(clk), .rst(rst), .wr(wr), .rd(rd), .icr_sel(icr_sel),
    .data_in(data_in), .ta_ovf(ta_ovf), .tb_ovf(tb_ovf),
    .icr_data(icr_data), .irq(irq)
  );

endmodule

//--- verif/cia_timer_properties.sv
/* Concurrent assertions on one interval timer, bound to every timer instance */
`timescale 1ns/1ps

module cia_timer_properties (
  input logic        clk,
  input logic        rst,
  input logic        wr,
  input logic        tcr,
  input logic        ovf,
  input logic [15:0] cnt,
  input logic [15:0] load_val,
  input logic        start,
  input logic        oneshot,
  input logic        count,
  input logic        underflow,
  input logic        thi_load,
  input logic        reload
);

  // Reset values of counter, start bit and underflow pulse
  assert property (@(posedge clk) rst |=> (cnt == 16'hFFFF) && !ovf && !start)
    else $error("timer reset values wrong");

  // Underflow pulse lasts one cycle
  assert property (@(posedge clk) disable iff (rst) ovf |=> !ovf)
    else $error("ovf pulse longer than one cycle");

  assert property (@(posedge clk) disable iff (rst)
    (underflow && oneshot && !(wr && tcr) && !thi_load) |=> !start)
    else $error("one-shot underflow did not clear start");

  assert property (@(posedge clk) disable iff (rst)
    (!reload && !(start && count)) |=> $stable(cnt))
    else $error("counter moved without count event or reload");

  assert property (@(posedge clk) disable iff (rst) reload |=> (cnt == $past(load_val)))
    else $error("reload did not take the latch value");

endmodule

bind cia_timer cia_timer_properties timer_props (
  .clk(clk), .rst(rst), .wr(wr), .tcr(tcr), .ovf(ovf), .cnt(cnt),
  .load_val(load_val), .start(start), .oneshot(oneshot), .count(count),
  .underflow(underflow), .thi_load(thi_load), .reload(reload)
);

//--- verif/cia_timer_tb.sv
/* Testbench for the dual interval timer with bus tasks, xorshift stimulus,
   a cycle model of both timers and the interrupt controller, and checks */
`timescale 1ns/1ps

module cia_timer_tb;

  // Roughly 80 bus accesses of up to 12 cycles, idle waits up to 25 cycles
  // and one-shot or cascade waits up to 4 latch periods of at most 41 ticks
  localparam int CYCLE_LIMIT = 4000;

  logic        clk;
  logic        rst;
  logic        tick;
  logic [4:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [4:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        irq;

  // Model state with index 0 for timer A and 1 for timer B
  logic [15:0] m_cnt [2];
  logic [7:0]  m_lat_lo [2];
  logic [7:0]  m_lat_hi [2];
  logic [1:0]  m_start, m_one, m_inm, m_ovf, m_thi, m_fl;
  logic [1:0]  m_flags, m_mask;
  logic        m_irq;
  logic [31:0] m_rd_exp;
  logic [1:0]  m_rd_resp;

  // Bus transfers seen by the model and applied one edge after the handshake
  logic        pw_v, pr_v, cap_tick;
  logic [4:0]  pw_addr, pr_addr;
  logic [7:0]  pw_data;
  logic        pw_strb;
  logic        last_hs_w, last_hs_r;

  logic [31:0] rng_state;
  int          tick_mode;
  int          cycles;
  int          errors;
  string       test_name;

  cia_timer_top cia_timer_top_inst (
    .clk(clk), .rst(rst), .tick(tick),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .irq(irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (cycles > CYCLE_LIMIT);
    $display("timeout: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic mapped(input logic [4:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= 5'h18);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", test_name, name, exp, act);
      errors++;
    end
  endtask

  // One clock of the model from the state before the edge
  task automatic model_step();
    logic [1:0] ov_old;
    logic       ev;
    logic       uf;
    logic       wrt;
    logic       nthi;
    logic       nfl;
    logic [4:0] lo_a;
    logic [4:0] cr_a;
    int         o;
    ov_old = m_ovf;
    wrt = pw_v && pw_strb;
    if (pr_v) begin
      m_rd_exp = 32'h0;
      m_rd_resp = mapped(pr_addr) ? 2'b00 : 2'b10;
      case (pr_addr)
        5'h00: m_rd_exp = {24'h0, m_cnt[0][7:0]};
        5'h04: m_rd_exp = {24'h0, m_cnt[0][15:8]};
        5'h08: m_rd_exp = {24'h0, m_cnt[1][7:0]};
        5'h0C: m_rd_exp = {24'h0, m_cnt[1][15:8]};
        5'h10: m_rd_exp = {24'h0, m_irq, 5'b0, m_flags};
        5'h14: m_rd_exp = {24'h0, 2'b0, m_inm[0], 1'b0, m_one[0], 2'b0, m_start[0]};
        5'h18: m_rd_exp = {24'h0, 2'b0, m_inm[1], 1'b0, m_one[1], 2'b0, m_start[1]};
        default: m_rd_exp = 32'h0;
      endcase
    end
    for (int t = 0; t < 2; t++) begin
      o = 1 - t;
      lo_a = 5'(8 * t);
      cr_a = 5'(20 + 4 * t);
      ev = m_inm[t] ? ov_old[o] : cap_tick;
      uf = m_start[t] && ev && (m_cnt[t] == 16'h0);
      nthi = wrt && (pw_addr == lo_a + 5'd4) && (!m_start[t] || m_one[t]);
      nfl = wrt && (pw_addr == cr_a) && pw_data[4];
      if (m_thi[t] || m_fl[t] || uf) begin
        m_cnt[t] = {m_lat_hi[t], m_lat_lo[t]};
      end else if (m_start[t] && ev) begin
        m_cnt[t] = m_cnt[t] - 16'd1;
      end
      if (wrt && (pw_addr == cr_a)) begin
        m_start[t] = pw_data[0];
        m_one[t] = pw_data[3];
        m_inm[t] = pw_data[5];
      end else if (m_thi[t] && m_one[t]) begin
        m_start[t] = 1'b1;
      end else if (uf && m_one[t]) begin
        m_start[t] = 1'b0;
      end
      if (wrt && (pw_addr == lo_a)) m_lat_lo[t] = pw_data;
      if (wrt && (pw_addr == lo_a + 5'd4)) m_lat_hi[t] = pw_data;
      m_thi[t] = nthi;
      m_fl[t] = nfl;
      m_ovf[t] = uf;
    end
    // Set wins over the clearing read
    if (pr_v && (pr_addr == 5'h10)) begin
      m_flags = ov_old;
    end else begin
      m_flags = m_flags | ov_old;
    end
    if (wrt && (pw_addr == 5'h10)) begin
      if (pw_data[7]) m_mask = m_mask | pw_data[1:0];
      else m_mask = m_mask & ~pw_data[1:0];
    end
    m_irq = |(m_flags & m_mask);
  endtask

  // Entered and left at the falling edge
  task automatic cycle();
    logic [31:0] r;
    r = xorshift();
    case (tick_mode)
      1: tick = r[3];
      2: tick = 1'b1;
      default: tick = 1'b0;
    endcase
    #1;
    check_value("irq", {31'h0, m_irq}, {31'h0, irq});
    // Write address and data channels are accepted together
    check_value("wready", {31'h0, awready}, {31'h0, wready});
    cap_tick = tick;
    last_hs_w = awready;
    last_hs_r = arready;
    @(posedge clk);
    model_step();
    pw_v = last_hs_w;
    pw_addr = awaddr;
    pw_data = wdata[7:0];
    pw_strb = wstrb[0];
    pr_v = last_hs_r;
    pr_addr = araddr;
    @(negedge clk);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) cycle();
  endtask

  task automatic axil_write(input logic [4:0] addr, input logic [7:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int stall;
    awaddr = addr;
    wdata = {24'h0, data};
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    last_hs_w = 1'b0;
    while (!last_hs_w) cycle();
    awvalid = 1'b0;
    wvalid = 1'b0;
    check_value("bvalid after handshake", 32'h1, {31'h0, bvalid});
    stall = int'(xorshift() % 4);
    bready = 1'b0;
    forever begin
      if (stall == 0) bready = 1'b1;
      if (bvalid && bready) break;
      stall--;
      cycle();
    end
    resp = bresp;
    cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int stall;
    araddr = addr;
    arvalid = 1'b1;
    last_hs_r = 1'b0;
    while (!last_hs_r) cycle();
    arvalid = 1'b0;
    stall = int'(xorshift() % 4);
    rready = 1'b0;
    forever begin
      if (stall == 0) rready = 1'b1;
      if (rvalid && rready) break;
      stall--;
      cycle();
    end
    data = rdata;
    resp = rresp;
    cycle();
    rready = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
    logic [1:0] resp;
    axil_write(addr, data, 4'hF, resp);
    check_value("bresp", {30'h0, mapped(addr) ? 2'b00 : 2'b10}, {30'h0, resp});
  endtask

  task automatic read_check(input string name, input logic [4:0] addr,
                            output logic [31:0] data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value(name, m_rd_exp, data);
    check_value({name, " rresp"}, {30'h0, m_rd_resp}, {30'h0, resp});
  endtask

  initial begin
    logic [31:0] d;
    logic [1:0]  resp;
    logic [7:0]  lat;
    logic [7:0]  rst_val [7];
    rst_val = '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'h00, 8'h00, 8'h00};
    rng_state = 32'd34614;
    errors = 0;
    cycles = 0;
    tick_mode = 0;
    rst = 1'b1;
    tick = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    for (int t = 0; t < 2; t++) begin
      m_cnt[t] = 16'hFFFF;
      m_lat_lo[t] = 8'hFF;
      m_lat_hi[t] = 8'hFF;
    end
    {m_start, m_one, m_inm, m_ovf, m_thi, m_fl, m_flags, m_mask} = '0;
    m_irq = 1'b0;
    {pw_v, pr_v, cap_tick} = '0;
    test_name = "reset";
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_value("idle outputs", 32'h0,
                {26'h0, awready, wready, arready, bvalid, rvalid, irq});
    rst = 1'b0;

    for (int i = 0; i < 7; i++) begin
      read_check("reset read", 5'(4 * i), d);
      check_value("reset value", {24'h0, rst_val[i]}, d);
    end
    write_reg(5'h14, 8'hDE);
    read_check("cra unused bits", 5'h14, d);
    check_value("cra readback", 32'h08, d);
    write_reg(5'h14, 8'h00);
    write_reg(5'h00, 8'h12);
    read_check("latch hidden", 5'h00, d);

    test_name = "continuous";
    lat = 8'(2 + xorshift() % 39);
    write_reg(5'h00, lat);
    write_reg(5'h04, 8'h00);
    write_reg(5'h10, 8'h81);
    write_reg(5'h14, 8'h01);
    tick_mode = 1;
    for (int i = 0; i < 8; i++) begin
      run_cycles(int'(xorshift() % 25));
      read_check("ta_lo", 5'h00, d);
      read_check("ta_hi", 5'h04, d);
      read_check("icr", 5'h10, d);
    end

    test_name = "oneshot";
    tick_mode = 2;
    write_reg(5'h14, 8'h00);
    lat = 8'(2 + xorshift() % 39);
    write_reg(5'h00, lat);
    write_reg(5'h04, 8'h00);
    write_reg(5'h14, 8'h09);
    run_cycles(int'(lat) + 4);
    read_check("cra stopped", 5'h14, d);
    check_value("start cleared", 32'h0, d & 32'h1);
    // No ticks, so the restarted timer cannot run out before the read
    tick_mode = 0;
    write_reg(5'h04, 8'h00);
    read_check("cra restarted", 5'h14, d);
    check_value("start set", 32'h1, d & 32'h1);
    read_check("icr", 5'h10, d);
    write_reg(5'h14, 8'h00);
    write_reg(5'h00, 8'h05);
    write_reg(5'h14, 8'h10);
    read_check("forceload lo", 5'h00, d);
    check_value("forceload value", 32'h05, d);
    read_check("forceload cr", 5'h14, d);

    test_name = "cascade";
    tick_mode = 2;
    lat = 8'(3 + xorshift() % 6);
    write_reg(5'h00, lat);
    write_reg(5'h04, 8'h00);
    write_reg(5'h08, 8'h03);
    write_reg(5'h0C, 8'h00);
    write_reg(5'h10, 8'h82);
    write_reg(5'h18, 8'h21);
    write_reg(5'h14, 8'h01);
    for (int i = 0; i < 6; i++) begin
      run_cycles(3 * (int'(lat) + 1));
      read_check("tb_lo", 5'h08, d);
      read_check("tb_hi", 5'h0C, d);
      read_check("icr", 5'h10, d);
    end

    test_name = "interrupt";
    write_reg(5'h10, 8'h03);
    run_cycles(20);
    read_check("icr masked", 5'h10, d);
    write_reg(5'h10, 8'h81);
    run_cycles(int'(xorshift() % 20));
    read_check("icr set a", 5'h10, d);
    read_check("icr cleared", 5'h10, d);

    test_name = "bus";
    tick_mode = 1;
    axil_write(5'h1C, 8'h55, 4'hF, resp);
    check_value("unmapped bresp", 32'h2, {30'h0, resp});
    read_check("unmapped read", 5'h1C, d);
    check_value("unmapped data", 32'h0, d);
    axil_write(5'h18, 8'h00, 4'hE, resp);
    check_value("strb bresp", 32'h0, {30'h0, resp});
    read_check("crb unchanged", 5'h18, d);
    for (int i = 0; i < 6; i++) begin
      read_check("random read", 5'(4 * (xorshift() % 7)), d);
    end

    $display("checks done after %0d cycles, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
